/* hw/armTypesPkg.sv */
package armTypesPkg;

  // Data value, address or instruction word
  typedef logic [31:0] word;

  // Register number
  // r15 reads as the branch base PC+8
  typedef logic [3:0] regAddr;

  // Condition flags, N Z C V from msb down
  typedef logic [3:0] flags;

  // Flag bit positions
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // Register number that maps to the PC
  localparam regAddr pcReg = 4'd15;

endpackage

/* hw/armIsaPkg.sv */
package armIsaPkg;

  // Instruction class, bits 27:26
  typedef enum logic [1:0] {
    clsData   = 2'b00,
    clsMem    = 2'b01,
    clsBranch = 2'b10
  } instrClass;

  // ALU command, ARM opcode bits 24:21
  typedef enum logic [3:0] {
    cmdAnd = 4'b0000,
    cmdSub = 4'b0010,
    cmdAdd = 4'b0100,
    cmdOrr = 4'b1100,
    cmdMov = 4'b1101
  } aluCmd;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    condEq = 4'b0000,
    condNe = 4'b0001,
    condGe = 4'b1010,
    condLt = 4'b1011,
    condAl = 4'b1110
  } condCode;

  // Field positions
  localparam int condHi  = 31;
  localparam int condLo  = 28;
  localparam int classHi = 27;
  localparam int classLo = 26;
  localparam int immBit  = 25;
  localparam int cmdHi   = 24;
  localparam int cmdLo   = 21;
  localparam int upBit   = 23;
  // S for data processing, L for LDR/STR
  localparam int sBit    = 20;
  localparam int rnHi    = 19;
  localparam int rnLo    = 16;
  localparam int rdHi    = 15;
  localparam int rdLo    = 12;
  localparam int rmHi    = 3;
  localparam int rmLo    = 0;

  // MOV r0, r0 under AL, decoded as a bubble
  localparam logic [31:0] nopInstr = 32'hE1A0_0000;

endpackage

/* hw/regFile.sv */
`timescale 1ns/1ps

module regFile import armTypesPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  regAddr rdAddrA,
  input  regAddr rdAddrB,
  output word    rdDataA,
  output word    rdDataB,
  input  logic   wrEn,
  input  regAddr wrAddr,
  input  word    wrData,
  input  word    pcPlus8
);

  word regs [0:14];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 15; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && wrAddr != pcReg) begin
      regs[wrAddr] <= wrData;
    end
  end

  // r15 is the PC, same-cycle writes bypass the array
  always_comb begin
    if (rdAddrA == pcReg)                 rdDataA = pcPlus8;
    else if (wrEn && wrAddr == rdAddrA)   rdDataA = wrData;
    else                                  rdDataA = regs[rdAddrA];
    if (rdAddrB == pcReg)                 rdDataB = pcPlus8;
    else if (wrEn && wrAddr == rdAddrB)   rdDataB = wrData;
    else                                  rdDataB = regs[rdAddrB];
  end

endmodule

/* hw/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage import armTypesPkg::*, armIsaPkg::*; #(
  parameter word resetAddr = '0
) (
  input  logic clk,
  input  logic rstN,
  input  logic branchTaken,
  input  word  branchTarget,
  input  word  instruction,
  output word  pc,
  output word  instrD,
  output word  pcPlus8D
);

  word pcPlus4;
  word pcNext;

  assign pcPlus4 = pc + 32'd4;
  assign pcNext  = branchTaken ? branchTarget : pcPlus4;

  // PC and the fetched word, a taken branch kills the fetch
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc     <= resetAddr;
      instrD <= nopInstr;
    end else begin
      pc     <= pcNext;
      instrD <= branchTaken ? nopInstr : instruction;
    end
  end

  // Address of the decoded instruction plus 8
  always_ff @(posedge clk) begin
    pcPlus8D <= pcPlus4 + 32'd4;
  end

  // Branch targets from execute must keep the PC aligned
  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

/* hw/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import armTypesPkg::*, armIsaPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  word     instrD,
  input  word     pcPlus8D,
  input  logic    flush,
  input  word     resultW,
  input  logic    regWriteW,
  input  regAddr  destW,
  output logic    regWriteE,
  output logic    memWriteE,
  output logic    memToRegE,
  output logic    isBranchE,
  output aluCmd   aluCmdE,
  output logic    setFlagsE,
  output logic    useImmE,
  output condCode condE,
  output word     rdAE,
  output word     rdBE,
  output word     immE,
  output regAddr  destE
);

  instrClass cls;
  logic      isNop;
  logic      isData;
  logic      isMem;
  logic      isLoad;
  regAddr    rn;
  regAddr    rd;
  regAddr    rm;
  regAddr    addrB;
  word       rdDataA;
  word       rdDataB;
  word       immD;
  aluCmd     cmdD;

  assign cls    = instrClass'(instrD[classHi:classLo]);
  assign isNop  = (instrD == nopInstr);
  assign isData = (cls == clsData) && !isNop;
  assign isMem  = (cls == clsMem);
  assign isLoad = isMem && instrD[sBit];

  assign rn = instrD[rnHi:rnLo];
  assign rd = instrD[rdHi:rdLo];
  assign rm = instrD[rmHi:rmLo];

  // Stores read Rd on port B as the store data
  assign addrB = isMem ? rd : rm;

  regFile uRegs (
    .clk    (clk),
    .rstN   (rstN),
    .rdAddrA(rn),
    .rdAddrB(addrB),
    .rdDataA(rdDataA),
    .rdDataB(rdDataB),
    .wrEn   (regWriteW),
    .wrAddr (destW),
    .wrData (resultW),
    .pcPlus8(pcPlus8D)
  );

  // Immediate and ALU command by class
  always_comb begin
    case (cls)
      clsMem: begin
        immD = {20'b0, instrD[11:0]};
        // U bit picks add or subtract of the offset
        cmdD = instrD[upBit] ? cmdAdd : cmdSub;
      end
      clsBranch: begin
        // Branch immediate already holds the target
        immD = pcPlus8D + {{6{instrD[23]}}, instrD[23:0], 2'b00};
        cmdD = cmdAdd;
      end
      default: begin
        immD = {24'b0, instrD[7:0]};
        cmdD = aluCmd'(instrD[cmdHi:cmdLo]);
      end
    endcase
  end

  // Control bits, cleared on flush
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      isBranchE <= 1'b0;
      setFlagsE <= 1'b0;
    end else begin
      regWriteE <= !flush && (isData || isLoad);
      memWriteE <= !flush && isMem && !instrD[sBit];
      memToRegE <= !flush && isLoad;
      isBranchE <= !flush && (cls == clsBranch);
      setFlagsE <= !flush && isData && instrD[sBit];
    end
  end

  always_ff @(posedge clk) begin
    aluCmdE <= cmdD;
    condE   <= condCode'(instrD[condHi:condLo]);
    useImmE <= isMem || (isData && instrD[immBit]);
    rdAE    <= rdDataA;
    rdBE    <= rdDataB;
    immE    <= immD;
    destE   <= rd;
  end

endmodule

/* hw/executeStage.sv */
`timescale 1ns/1ps

module executeStage import armTypesPkg::*, armIsaPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    regWriteE,
  input  logic    memWriteE,
  input  logic    memToRegE,
  input  logic    isBranchE,
  input  aluCmd   aluCmdE,
  input  logic    setFlagsE,
  input  logic    useImmE,
  input  condCode condE,
  input  word     rdAE,
  input  word     rdBE,
  input  word     immE,
  input  regAddr  destE,
  output logic    branchTaken,
  output word     branchTarget,
  output logic    regWriteM,
  output logic    memWriteM,
  output logic    memToRegM,
  output word     aluOutM,
  output word     storeDataM,
  output regAddr  destM
);

  word         srcB;
  word         aluResult;
  logic [32:0] wideSum;
  logic        carry;
  logic        overflow;
  logic        condPass;
  flags        flagReg;
  flags        aluFlags;

  assign srcB = useImmE ? immE : rdBE;

  // Logical ops and MOV leave C and V alone
  always_comb begin
    wideSum   = '0;
    aluResult = srcB;
    carry     = flagReg[flagC];
    overflow  = flagReg[flagV];
    case (aluCmdE)
      cmdAdd: begin
        wideSum   = {1'b0, rdAE} + {1'b0, srcB};
        aluResult = wideSum[31:0];
        carry     = wideSum[32];
        overflow  = (rdAE[31] == srcB[31]) && (aluResult[31] != rdAE[31]);
      end
      cmdSub: begin
        // Carry set means no borrow as on ARM
        wideSum   = {1'b0, rdAE} + {1'b0, ~srcB} + 33'd1;
        aluResult = wideSum[31:0];
        carry     = wideSum[32];
        overflow  = (rdAE[31] != srcB[31]) && (aluResult[31] != rdAE[31]);
      end
      cmdAnd:  aluResult = rdAE & srcB;
      cmdOrr:  aluResult = rdAE | srcB;
      default: aluResult = srcB;
    endcase
  end

  assign aluFlags = {aluResult[31], aluResult == '0, carry, overflow};

  always_comb begin
    case (condE)
      condEq:  condPass = flagReg[flagZ];
      condNe:  condPass = !flagReg[flagZ];
      condGe:  condPass = flagReg[flagN] == flagReg[flagV];
      condLt:  condPass = flagReg[flagN] != flagReg[flagV];
      condAl:  condPass = 1'b1;
      default: condPass = 1'b0;
    endcase
  end

  assign branchTaken  = isBranchE && condPass;
  assign branchTarget = immE;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagReg <= '0;
    end else if (setFlagsE && condPass) begin
      flagReg <= aluFlags;
    end
  end

  // Failed conditions leave a bubble
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
    end else begin
      regWriteM <= regWriteE && condPass;
      memWriteM <= memWriteE && condPass;
      memToRegM <= memToRegE && condPass;
    end
  end

  always_ff @(posedge clk) begin
    aluOutM    <= aluResult;
    storeDataM <= rdBE;
    destM      <= destE;
  end

  // The slot behind a taken branch arrives here as a bubble
  flushBubble: assert property (@(posedge clk) disable iff (!rstN)
    branchTaken |=> !(regWriteE || memWriteE || setFlagsE || isBranchE))
    else $error("instruction behind a taken branch was not flushed");

endmodule

/* hw/memoryStage.sv */
`timescale 1ns/1ps

module memoryStage import armTypesPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   regWriteM,
  input  logic   memWriteM,
  input  logic   memToRegM,
  input  word    aluOutM,
  input  word    storeDataM,
  input  regAddr destM,
  input  word    readData,
  output word    dataAddr,
  output word    writeData,
  output logic   memWrite,
  output word    resultW,
  output logic   regWriteW,
  output regAddr destW
);

  logic memToRegW;
  word  readDataW;
  word  aluOutW;

  // Data memory sees the execute/memory register directly
  assign dataAddr  = aluOutM;
  assign writeData = storeDataM;
  assign memWrite  = memWriteM;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteW <= 1'b0;
    end else begin
      regWriteW <= regWriteM;
    end
  end

  always_ff @(posedge clk) begin
    memToRegW <= memToRegM;
    readDataW <= readData;
    aluOutW   <= aluOutM;
    destW     <= destM;
  end

  // Writeback select
  assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

/* hw/armCpu.sv */
`timescale 1ns/1ps

module armCpu import armTypesPkg::*, armIsaPkg::*; #(
  parameter word resetAddr = '0
) (
  input  logic clk,
  input  logic rstN,
  input  word  instruction,
  input  word  readData,
  output word  pc,
  output word  dataAddr,
  output word  writeData,
  output logic memWrite
);

  // Fetch to decode
  word     instrD;
  word     pcPlus8D;

  // Decode to execute
  logic    regWriteE;
  logic    memWriteE;
  logic    memToRegE;
  logic    isBranchE;
  logic    setFlagsE;
  logic    useImmE;
  aluCmd   aluCmdE;
  condCode condE;
  word     rdAE;
  word     rdBE;
  word     immE;
  regAddr  destE;

  // Execute to memory, and the branch back to fetch
  logic    branchTaken;
  word     branchTarget;
  logic    regWriteM;
  logic    memWriteM;
  logic    memToRegM;
  word     aluOutM;
  word     storeDataM;
  regAddr  destM;

  // Writeback into the register file
  word     resultW;
  logic    regWriteW;
  regAddr  destW;

  fetchStage #(
    .resetAddr(resetAddr)
  ) uFetch (
    .clk         (clk),
    .rstN        (rstN),
    .branchTaken (branchTaken),
    .branchTarget(branchTarget),
    .instruction (instruction),
    .pc          (pc),
    .instrD      (instrD),
    .pcPlus8D    (pcPlus8D)
  );

  decodeStage uDecode (
    .clk       (clk),
    .rstN      (rstN),
    .instrD    (instrD),
    .pcPlus8D  (pcPlus8D),
    .flush     (branchTaken),
    .resultW   (resultW),
    .regWriteW (regWriteW),
    .destW     (destW),
    .regWriteE (regWriteE),
    .memWriteE (memWriteE),
    .memToRegE (memToRegE),
    .isBranchE (isBranchE),
    .aluCmdE   (aluCmdE),
    .setFlagsE (setFlagsE),
    .useImmE   (useImmE),
    .condE     (condE),
    .rdAE      (rdAE),
    .rdBE      (rdBE),
    .immE      (immE),
    .destE     (destE)
  );

  executeStage uExecute (
    .clk         (clk),
    .rstN        (rstN),
    .regWriteE   (regWriteE),
    .memWriteE   (memWriteE),
    .memToRegE   (memToRegE),
    .isBranchE   (isBranchE),
    .aluCmdE     (aluCmdE),
    .setFlagsE   (setFlagsE),
    .useImmE     (useImmE),
    .condE       (condE),
    .rdAE        (rdAE),
    .rdBE        (rdBE),
    .immE        (immE),
    .destE       (destE),
    .branchTaken (branchTaken),
    .branchTarget(branchTarget),
    .regWriteM   (regWriteM),
    .memWriteM   (memWriteM),
    .memToRegM   (memToRegM),
    .aluOutM     (aluOutM),
    .storeDataM  (storeDataM),
    .destM       (destM)
  );

  memoryStage uMemory (
    .clk       (clk),
    .rstN      (rstN),
    .regWriteM (regWriteM),
    .memWriteM (memWriteM),
    .memToRegM (memToRegM),
    .aluOutM   (aluOutM),
    .storeDataM(storeDataM),
    .destM     (destM),
    .readData  (readData),
    .dataAddr  (dataAddr),
    .writeData (writeData),
    .memWrite  (memWrite),
    .resultW   (resultW),
    .regWriteW (regWriteW),
    .destW     (destW)
  );

endmodule

/* verif/armCpuTb.sv */
`timescale 1ns/1ps

module armCpuTb import armTypesPkg::*, armIsaPkg::*; ();

  typedef enum logic [2:0] {
    kindAluReg,
    kindAluImm,
    kindCond,
    kindMem,
    kindBranch
  } testKind;

  typedef struct packed {
    testKind kind;
    aluCmd   cmd;
    condCode cond;
    word     a;
    word     b;
    logic    rnd;
  } testRow;

  localparam int numRows = 20;

  logic clk = 1'b0;
  logic rstN;
  word  instruction;
  word  readData;
  word  pc;
  word  dataAddr;
  word  writeData;
  logic memWrite;

  word    rom [0:63];
  word    dataRam [0:63];
  word    opA;
  word    opB;
  testRow rows [0:numRows-1];
  word    expAddr [$];
  word    expData [$];
  int     progLen;
  int     passCount;
  int     failCount;

  armCpu #(
    .resetAddr(32'd0)
  ) UUT (
    .clk        (clk),
    .rstN       (rstN),
    .instruction(instruction),
    .readData   (readData),
    .pc         (pc),
    .dataAddr   (dataAddr),
    .writeData  (writeData),
    .memWrite   (memWrite)
  );

  always #5 clk = ~clk;

  // Both memories answer combinationally
  assign instruction = (pc < 32'd256) ? rom[pc[7:2]] : nopInstr;
  assign readData    = dataRam[dataAddr[7:2]];

  // Reset refills the RAM with the operands at 0x80 and 0x84
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 64; i++) begin
        if (i == 32) dataRam[i] <= opA;
        else if (i == 33) dataRam[i] <= opB;
        else dataRam[i] <= 32'hDA7A_0000 | (word'(i) << 2);
      end
    end else if (memWrite) begin
      dataRam[dataAddr[7:2]] <= writeData;
    end
  end

  function automatic word dataOp(condCode c, aluCmd cmd, logic i, logic s,
                                 regAddr rn, regAddr rd, logic [7:0] op2);
    return {c, 2'b00, i, cmd, s, rn, rd, 4'h0, op2};
  endfunction

  // Pre-indexed word access without writeback
  function automatic word memOp(logic load, logic up, regAddr rn, regAddr rd,
                                logic [11:0] off);
    return {condAl, 2'b01, 1'b0, 1'b1, up, 2'b00, load, rn, rd, off};
  endfunction

  function automatic word branchOp(condCode c, logic [23:0] off);
    return {c, 3'b101, 1'b0, off};
  endfunction

  function automatic word aluModel(aluCmd cmd, word a, word b);
    word res;
    case (cmd)
      cmdAdd:  res = a + b;
      cmdSub:  res = a - b;
      cmdAnd:  res = a & b;
      cmdOrr:  res = a | b;
      default: res = b;
    endcase
    return res;
  endfunction

  // Condition evaluated on the flags of a - b
  function automatic logic condHolds(condCode c, word a, word b);
    word  diff;
    logic n;
    logic z;
    logic v;
    logic ok;
    diff = a - b;
    n = diff[31];
    z = (diff == 32'd0);
    v = (a[31] != b[31]) && (diff[31] != a[31]);
    case (c)
      condEq:  ok = z;
      condNe:  ok = !z;
      condGe:  ok = (n == v);
      condLt:  ok = (n != v);
      default: ok = 1'b1;
    endcase
    return ok;
  endfunction

  task automatic emit(input word w);
    rom[progLen] = w;
    progLen++;
  endtask

  task automatic emitNops(input int count);
    repeat (count) emit(nopInstr);
  endtask

  task automatic expectStore(input word addr, input word data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic fillTable();
    rows[0]  = '{kindAluReg, cmdAdd, condAl, 32'h7FFF_FFFF, 32'h0000_0001, 1'b0};
    rows[1]  = '{kindAluReg, cmdSub, condAl, 32'h0000_0005, 32'h0000_0009, 1'b0};
    rows[2]  = '{kindAluReg, cmdAnd, condAl, 32'h0, 32'h0, 1'b1};
    rows[3]  = '{kindAluReg, cmdOrr, condAl, 32'h0, 32'h0, 1'b1};
    rows[4]  = '{kindAluReg, cmdMov, condAl, 32'h0, 32'h0, 1'b1};
    rows[5]  = '{kindAluReg, cmdAdd, condAl, 32'h0, 32'h0, 1'b1};
    rows[6]  = '{kindAluImm, cmdAdd, condAl, 32'hFFFF_FFF0, 32'h0000_0020, 1'b0};
    rows[7]  = '{kindAluImm, cmdSub, condAl, 32'h0, 32'h0, 1'b1};
    rows[8]  = '{kindAluImm, cmdAnd, condAl, 32'hF0F0_F0F0, 32'h0000_00FF, 1'b0};
    rows[9]  = '{kindAluImm, cmdOrr, condAl, 32'h0, 32'h0, 1'b1};
    rows[10] = '{kindAluImm, cmdMov, condAl, 32'h1234_5678, 32'h0000_00A5, 1'b0};
    rows[11] = '{kindCond, cmdAdd, condEq, 32'h0000_0007, 32'h0000_0007, 1'b0};
    rows[12] = '{kindCond, cmdAdd, condNe, 32'h0, 32'h0, 1'b1};
    rows[13] = '{kindCond, cmdAdd, condGe, 32'h0000_0003, 32'h0000_0009, 1'b0};
    // Signed overflow on the compare
    rows[14] = '{kindCond, cmdAdd, condLt, 32'h8000_0000, 32'h0000_0001, 1'b0};
    rows[15] = '{kindMem, cmdAdd, condAl, 32'h0, 32'h0000_0008, 1'b1};
    rows[16] = '{kindMem, cmdAdd, condAl, 32'hCAFE_F00D, 32'hFFFF_FFF4, 1'b0};
    rows[17] = '{kindBranch, cmdAdd, condAl, 32'h0, 32'h0, 1'b1};
    rows[18] = '{kindBranch, cmdAdd, condEq, 32'h0000_0004, 32'h0000_0005, 1'b0};
    rows[19] = '{kindBranch, cmdAdd, condLt, 32'h0, 32'h0, 1'b1};
  endtask

  // Program and expected stores for one row
  task automatic buildProgram(input testRow row);
    word         diff;
    word         negB;
    logic        up;
    logic [11:0] off;
    diff = row.a - row.b;
    negB = -row.b;
    up   = !row.b[31];
    off  = up ? row.b[11:0] : negB[11:0];
    for (int i = 0; i < 64; i++) begin
      rom[i] = nopInstr;
    end
    expAddr.delete();
    expData.delete();
    progLen = 0;
    emit(memOp(1'b1, 1'b1, 4'd0, 4'd1, 12'h080));
    emit(memOp(1'b1, 1'b1, 4'd0, 4'd2, 12'h084));
    emit(dataOp(condAl, cmdMov, 1'b1, 1'b0, 4'd0, 4'd4, 8'h11));
    emitNops(2);
    case (row.kind)
      kindAluReg: begin
        emit(dataOp(condAl, row.cmd, 1'b0, 1'b0, 4'd1, 4'd3, 8'h02));
        emitNops(2);
        emit(memOp(1'b0, 1'b1, 4'd0, 4'd3, 12'h000));
        expectStore(32'h0, aluModel(row.cmd, row.a, row.b));
      end
      kindAluImm: begin
        emit(dataOp(condAl, row.cmd, 1'b1, 1'b0, 4'd1, 4'd3, row.b[7:0]));
        emitNops(2);
        emit(memOp(1'b0, 1'b1, 4'd0, 4'd3, 12'h000));
        expectStore(32'h0, aluModel(row.cmd, row.a, {24'h0, row.b[7:0]}));
      end
      kindCond: begin
        emit(dataOp(condAl, cmdSub, 1'b0, 1'b1, 4'd1, 4'd3, 8'h02));
        emit(dataOp(row.cond, cmdAdd, 1'b1, 1'b0, 4'd4, 4'd4, 8'h44));
        emitNops(2);
        emit(memOp(1'b0, 1'b1, 4'd0, 4'd4, 12'h000));
        expectStore(32'h0, condHolds(row.cond, row.a, row.b) ? 32'h55 : 32'h11);
      end
      kindMem: begin
        emit(dataOp(condAl, cmdMov, 1'b1, 1'b0, 4'd0, 4'd5, 8'h40));
        emitNops(2);
        emit(memOp(1'b0, up, 4'd5, 4'd1, off));
        emit(memOp(1'b1, up, 4'd5, 4'd6, off));
        emitNops(2);
        emit(memOp(1'b0, 1'b1, 4'd0, 4'd6, 12'h010));
        expectStore(32'h40 + row.b, row.a);
        expectStore(32'h10, row.a);
      end
      default: begin
        // Target is three slots past the branch
        emit(dataOp(condAl, cmdSub, 1'b0, 1'b1, 4'd1, 4'd3, 8'h02));
        emit(branchOp(row.cond, 24'd1));
        emit(memOp(1'b0, 1'b1, 4'd0, 4'd1, 12'h004));
        emit(memOp(1'b0, 1'b1, 4'd0, 4'd2, 12'h008));
        emit(memOp(1'b0, 1'b1, 4'd0, 4'd3, 12'h00C));
        if (!condHolds(row.cond, row.a, row.b)) begin
          expectStore(32'h4, row.a);
          expectStore(32'h8, row.b);
        end
        expectStore(32'hC, diff);
      end
    endcase
    // End marker
    emit(memOp(1'b0, 1'b1, 4'd0, 4'd0, 12'h03C));
    expectStore(32'h3C, 32'h0);
  endtask

  task automatic runRow(input int idx);
    testRow row;
    word    wantAddr;
    word    wantData;
    logic   done;
    logic   bad;
    row = rows[idx];
    bad = 1'b0;
    done = 1'b0;
    if (row.rnd) begin
      row.a = $urandom();
      if (row.kind != kindMem) row.b = $urandom();
    end
    @(negedge clk);
    opA = row.a;
    opB = row.b;
    rstN = 1'b0;
    buildProgram(row);
    repeat (5) begin
      @(negedge clk);
      if (memWrite !== 1'b0) begin
        $display("mismatch at %0t: test %0d memWrite %b during reset, expected 0",
                 $time, idx, memWrite);
        bad = 1'b1;
      end
    end
    rstN = 1'b1;
    if (pc !== 32'd0) begin
      $display("mismatch at %0t: test %0d pc %h after reset, expected 0", $time, idx, pc);
      bad = 1'b1;
    end
    while (!done) begin
      @(negedge clk);
      if (memWrite === 1'b1) begin
        if (expAddr.size() == 0) begin
          $display("mismatch at %0t: test %0d unexpected store %h to %h",
                   $time, idx, writeData, dataAddr);
          bad = 1'b1;
        end else begin
          wantAddr = expAddr.pop_front();
          wantData = expData.pop_front();
          if (dataAddr !== wantAddr || writeData !== wantData) begin
            $display("mismatch at %0t: test %0d store %h to %h, expected %h to %h",
                     $time, idx, writeData, dataAddr, wantData, wantAddr);
            bad = 1'b1;
          end
        end
        if (dataAddr == 32'h3C) done = 1'b1;
      end
    end
    if (expAddr.size() != 0) begin
      $display("test %0d: %0d expected stores never appeared", idx, expAddr.size());
      bad = 1'b1;
    end
    if (bad) failCount++;
    else passCount++;
    $display("test %0d %s a=%h b=%h: %s", idx, row.kind.name(), row.a, row.b,
             bad ? "failed" : "passed");
  endtask

  initial begin
    void'($urandom(32613));
    opA = '0;
    opB = '0;
    passCount = 0;
    failCount = 0;
    progLen = 0;
    for (int i = 0; i < 64; i++) begin
      rom[i] = nopInstr;
    end
    rstN = 1'b0;
    fillTable();
    for (int r = 0; r < numRows; r++) begin
      runRow(r);
    end
    $display("tests passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Each row needs well under 100 cycles
  initial begin
    repeat (numRows * 100) @(posedge clk);
    $display("run timed out after %0d cycles", numRows * 100);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* sim.f */
hw/armTypesPkg.sv
hw/armIsaPkg.sv
hw/regFile.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/armCpu.sv
verif/armCpuTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module armCpuTb -Mdir obj_dir &&
./obj_dir/VarmCpuTb > sim.log 2>&1 ;
cat sim.log 2>/dev/null ;
grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
